// ==== source/etx_config.svh ====
`ifndef ETX_CONFIG_SVH
`define ETX_CONFIG_SVH

// ##########################################################################
// link transmit build constants
// ##########################################################################

// packet width, one emesh transaction
`define ETX_PW               104

// register file address width (word address bits)
`define ETX_RFAW             6

// register word addresses, mi_addr[RFAW+1:2]
`define ETX_CFG              0
`define ETX_STATUS           1
`define ETX_GPIO             2
`define E_VERSION            3

// packet buffer entries, power of two
`define ETX_FIFO_DEPTH       4

// version register value out of reset
`define ETX_DEFAULT_VERSION  16'h0102

`endif

// ==== source/etx_pkg.sv ====
`default_nettype none

package etx_pkg;

   // ########################################################################
   // packet layout
   // ########################################################################

   // control mode tag carried with every transaction
   typedef logic [3:0] ctrlmode_t;

   // first field sits on top, write ends up in bit 0
   typedef struct packed {
      logic [31:0] srcaddr;   // bits 103:72
      logic [31:0] data;      // bits 71:40
      logic [31:0] dstaddr;   // bits 39:8
      ctrlmode_t   ctrlmode;  // bits 7:4
      logic        reserved;  // bit 3
      logic [1:0]  datamode;  // bits 2:1
      logic        write;     // bit 0
   } packet_t;

   // ########################################################################
   // status word bit positions
   // ########################################################################

   localparam int st_sent     = 0;  // pulse, last byte of a frame
   localparam int st_full     = 1;  // buffer full
   localparam int st_drop     = 2;  // pulse, packet discarded
   localparam int st_count_lo = 3;  // buffer occupancy
   localparam int st_count_hi = 5;
   localparam int st_busy     = 6;  // frame on the pins

endpackage

`default_nettype wire

// ==== source/etx_cfg.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "etx_config.svh"

module etx_cfg (
   input  wire                      clk,
   input  wire                      nreset,
   // memory interface
   input  wire                      mi_en,
   input  wire                      mi_we,
   input  wire [`ETX_RFAW+1:0]      mi_addr,   // byte address, 1:0 ignored
   input  wire [31:0]               mi_din,
   output logic [31:0]              mi_dout,
   // live status from the pipeline
   input  wire [15:0]               tx_status,
   // static link controls
   output logic                     tx_enable,
   output logic                     remap_enable,
   output logic                     gpio_enable,
   output logic [8:0]               gpio_data,
   output etx_pkg::ctrlmode_t       ctrlmode,
   output logic                     ctrlmode_bypass
);

   logic [10:0]          cfg_reg;      // main config
   logic [2:0]           status_reg;   // sticky bits
   logic [8:0]           gpio_reg;     // static pin values
   logic [15:0]          version_reg;
   logic [`ETX_RFAW-1:0] word_addr;
   logic                 rd;
   logic                 wr;
   logic                 cfg_wr;
   logic                 status_wr;
   logic                 gpio_wr;
   logic                 version_wr;

   // ##########################################################################
   // decode
   // ##########################################################################

   assign word_addr  = mi_addr[`ETX_RFAW+1:2];  // drop byte offset
   assign wr         = mi_en & mi_we;
   assign rd         = mi_en & ~mi_we;

   assign cfg_wr     = wr & (word_addr == `ETX_CFG);
   assign status_wr  = wr & (word_addr == `ETX_STATUS);
   assign gpio_wr    = wr & (word_addr == `ETX_GPIO);
   assign version_wr = wr & (word_addr == `E_VERSION);

   // ##########################################################################
   // config register
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!nreset)
         cfg_reg <= '0;
      else if (cfg_wr)
         cfg_reg <= mi_din[10:0];
   end

   // bit 1 (mmu) is kept for software, nothing uses it here
   assign tx_enable       = cfg_reg[0];
   assign remap_enable    = (cfg_reg[3:2] == 2'b01);   // alias mode only
   assign ctrlmode        = cfg_reg[7:4];
   assign ctrlmode_bypass = cfg_reg[8];
   assign gpio_enable     = (cfg_reg[10:9] == 2'b01);  // pin forcing

   // sticky status, write loads, otherwise accumulate
   always_ff @(posedge clk) begin
      if (!nreset)
         status_reg <= '0;
      else if (status_wr)
         status_reg <= mi_din[2:0];
      else
         status_reg <= status_reg | tx_status[etx_pkg::st_drop:etx_pkg::st_sent];
   end

   // pin values, only meaningful once forcing is on
   always_ff @(posedge clk) begin
      if (gpio_wr)
         gpio_reg <= mi_din[8:0];
   end

   assign gpio_data = gpio_reg;

   always_ff @(posedge clk) begin
      if (!nreset)
         version_reg <= `ETX_DEFAULT_VERSION;
      else if (version_wr)
         version_reg <= mi_din[15:0];
   end

   // ##########################################################################
   // readback, one cycle behind the request
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!nreset)
         mi_dout <= '0;
      else if (rd) begin
         case (word_addr)
            `ETX_CFG:    mi_dout <= {21'b0, cfg_reg};
            `ETX_STATUS: mi_dout <= {16'b0, tx_status[15:3], status_reg};
            `ETX_GPIO:   mi_dout <= {23'b0, gpio_reg};
            `E_VERSION:  mi_dout <= {16'b0, version_reg};
            default:     mi_dout <= '0;   // hole in the map
         endcase
      end
      else
         mi_dout <= '0;   // idle bus reads zero
   end

   // a request must say which way it goes
   assert property (@(posedge clk) disable iff (!nreset)
      mi_en |-> !$isunknown(mi_we))
      else $error("mi_we unknown during access");

endmodule

`default_nettype wire

// ==== source/etx_remap.sv ====
`timescale 1ns/1ns
`default_nettype none

module etx_remap (
   input  wire                  clk,
   input  wire                  nreset,
   // upstream link
   input  wire                  in_access,
   input  etx_pkg::packet_t     in_packet,
   output logic                 in_wait,
   // downstream link
   output logic                 out_access,
   output etx_pkg::packet_t     out_packet,
   input  wire                  out_wait,
   // controls from the register file
   input  wire                  tx_enable,
   input  wire                  remap_enable,
   input  etx_pkg::ctrlmode_t   ctrlmode,
   input  wire                  ctrlmode_bypass,
   output logic                 drop         // one cycle per discarded packet
);

   etx_pkg::packet_t next_packet;
   logic             accept;

   // stall only when the holding register cannot drain
   assign in_wait = out_access & out_wait;
   assign accept  = in_access & ~in_wait;

   // rewrite rules
   always_comb begin
      next_packet = in_packet;
      // short local address picks up the source's upper 12 bits
      if (remap_enable && (in_packet.dstaddr[31:20] == 12'h000))
         next_packet.dstaddr[31:20] = in_packet.srcaddr[31:20];
      if (ctrlmode_bypass)
         next_packet.ctrlmode = ctrlmode;   // force configured tag
   end

   always_ff @(posedge clk) begin
      if (!nreset) begin
         out_access <= 1'b0;
         drop       <= 1'b0;
      end
      else begin
         drop <= accept & ~tx_enable;              // swallowed, never forwarded
         if (!in_wait)
            out_access <= accept & tx_enable;      // reg empty or draining now
      end
   end

   // payload, no reset
   always_ff @(posedge clk) begin
      if (accept && tx_enable)
         out_packet <= next_packet;
   end

   // held packets must not change under back-pressure
   assert property (@(posedge clk) disable iff (!nreset)
      (out_access && out_wait) |=> $stable(out_packet))
      else $error("remap output changed while stalled");

endmodule

`default_nettype wire

// ==== source/etx_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "etx_config.svh"

module etx_fifo (
   input  wire                  clk,
   input  wire                  nreset,
   // write side
   input  wire                  in_access,
   input  etx_pkg::packet_t     in_packet,
   output logic                 in_wait,
   // read side
   output logic                 out_access,
   output etx_pkg::packet_t     out_packet,
   input  wire                  out_wait,
   // occupancy for status
   output logic [2:0]           count,
   output logic                 full
);

   localparam int aw = $clog2(`ETX_FIFO_DEPTH);   // pointer bits

   logic [`ETX_PW-1:0] mem [`ETX_FIFO_DEPTH];     // packet storage
   logic [aw-1:0]      wr_ptr;
   logic [aw-1:0]      rd_ptr;
   logic [2:0]         occ;                       // entries held
   logic               push;
   logic               pop;

   assign full       = (occ == `ETX_FIFO_DEPTH);
   assign in_wait    = full;
   assign out_access = (occ != '0);
   assign out_packet = mem[rd_ptr];               // head shows without delay
   assign count      = occ;

   assign push = in_access & ~in_wait;
   assign pop  = out_access & ~out_wait;

   // ##########################################################################
   // pointers and count
   // ##########################################################################

   always_ff @(posedge clk) begin
      if (!nreset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         occ    <= '0;
      end
      else begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         case ({push, pop})
            2'b10:   occ <= occ + 1'b1;
            2'b01:   occ <= occ - 1'b1;
            default: occ <= occ;     // both or neither
         endcase
      end
   end

   // storage, no reset
   always_ff @(posedge clk) begin
      if (push)
         mem[wr_ptr] <= in_packet;
   end

   // a push into a full buffer would overrun the count or skew the pointers
   assert property (@(posedge clk) disable iff (!nreset)
      (occ <= `ETX_FIFO_DEPTH) && (wr_ptr == aw'(rd_ptr + occ)))
      else $error("push accepted into full buffer");

endmodule

`default_nettype wire

// ==== source/etx_serializer.sv ====
`timescale 1ns/1ns
`default_nettype none

module etx_serializer (
   input  wire                  clk,
   input  wire                  nreset,
   // packet in
   input  wire                  in_access,
   input  etx_pkg::packet_t     in_packet,
   output logic                 in_wait,
   // pin forcing
   input  wire                  gpio_enable,
   input  wire [8:0]            gpio_data,
   // link pins
   output logic [7:0]           txo_data,
   output logic                 txo_frame,
   // status
   output logic                 sent,        // last byte going out
   output logic                 busy         // frame in progress
);

   localparam int pw     = $bits(etx_pkg::packet_t);
   localparam int nbytes = pw / 8;            // 13 bytes per frame

   logic [pw-1:0] shift_reg;                  // lsb byte on the pins
   logic [3:0]    byte_cnt;                   // 0 .. nbytes-1
   logic          last_byte;
   logic          accept;
   logic          ser_frame;
   logic [7:0]    ser_data;

   // ##########################################################################
   // handshake
   // ##########################################################################

   assign last_byte = busy & (byte_cnt == 4'(nbytes - 1));

   // take the next packet on the final byte so frames abut
   assign in_wait = gpio_enable | (busy & ~last_byte);
   assign accept  = in_access & ~in_wait;
   assign sent    = last_byte & ~gpio_enable;

   always_ff @(posedge clk) begin
      if (!nreset) begin
         busy     <= 1'b0;
         byte_cnt <= '0;
      end
      else if (!gpio_enable) begin          // frozen while pins forced
         if (accept) begin
            busy     <= 1'b1;
            byte_cnt <= '0;
         end
         else if (last_byte)
            busy <= 1'b0;                   // nothing queued, go idle
         else if (busy)
            byte_cnt <= byte_cnt + 1'b1;
      end
   end

   // payload path, no reset
   always_ff @(posedge clk) begin
      if (accept)
         shift_reg <= in_packet;
      else if (busy && !gpio_enable)
         shift_reg <= {8'h00, shift_reg[pw-1:8]};   // next byte down
   end

   // ##########################################################################
   // pin mux
   // ##########################################################################

   assign ser_frame = busy;
   assign ser_data  = busy ? shift_reg[7:0] : 8'h00;   // quiet between frames

   assign txo_frame = gpio_enable ? gpio_data[8]   : ser_frame;
   assign txo_data  = gpio_enable ? gpio_data[7:0] : ser_data;

   // a frame always opens on byte zero
   assert property (@(posedge clk) disable iff (!nreset)
      (!gpio_enable && !$past(gpio_enable) && $rose(txo_frame)) |-> (byte_cnt == '0))
      else $error("frame started mid packet");

endmodule

`default_nettype wire

// ==== source/etx_top.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "etx_config.svh"

module etx_top (
   input  wire                  clk,
   input  wire                  nreset,
   // register access
   input  wire                  mi_en,
   input  wire                  mi_we,
   input  wire [`ETX_RFAW+1:0]  mi_addr,
   input  wire [31:0]           mi_din,
   output wire [31:0]           mi_dout,
   // packet input
   input  wire                  pkt_access,
   input  etx_pkg::packet_t     pkt_in,
   output wire                  pkt_wait,
   // link pins
   output wire [7:0]            txo_data,
   output wire                  txo_frame
);

   // controls
   wire                      tx_enable;
   wire                      remap_enable;
   wire                      gpio_enable;
   wire [8:0]                gpio_data;
   etx_pkg::ctrlmode_t       ctrlmode;
   wire                      ctrlmode_bypass;
   // remap -> fifo
   wire                      rm_access;
   etx_pkg::packet_t         rm_packet;
   wire                      rm_wait;
   // fifo -> serializer
   wire                      ff_access;
   etx_pkg::packet_t         ff_packet;
   wire                      ff_wait;
   // status sources
   wire                      drop;
   wire [2:0]                ff_count;
   wire                      ff_full;
   wire                      ser_sent;
   wire                      ser_busy;
   wire [15:0]               tx_status;

   // ##########################################################################
   // status word
   // ##########################################################################

   assign tx_status[etx_pkg::st_sent]                          = ser_sent;
   assign tx_status[etx_pkg::st_full]                          = ff_full;
   assign tx_status[etx_pkg::st_drop]                          = drop;
   assign tx_status[etx_pkg::st_count_hi:etx_pkg::st_count_lo] = ff_count;
   assign tx_status[etx_pkg::st_busy]                          = ser_busy;
   assign tx_status[15:etx_pkg::st_busy+1]                     = '0;   // spare

   etx_cfg i_cfg (
      .clk(clk), .nreset(nreset),
      .mi_en(mi_en), .mi_we(mi_we), .mi_addr(mi_addr), .mi_din(mi_din),
      .mi_dout(mi_dout), .tx_status(tx_status),
      .tx_enable(tx_enable), .remap_enable(remap_enable),
      .gpio_enable(gpio_enable), .gpio_data(gpio_data),
      .ctrlmode(ctrlmode), .ctrlmode_bypass(ctrlmode_bypass)
   );

   etx_remap i_remap (
      .clk(clk), .nreset(nreset),
      .in_access(pkt_access), .in_packet(pkt_in), .in_wait(pkt_wait),
      .out_access(rm_access), .out_packet(rm_packet), .out_wait(rm_wait),
      .tx_enable(tx_enable), .remap_enable(remap_enable),
      .ctrlmode(ctrlmode), .ctrlmode_bypass(ctrlmode_bypass), .drop(drop)
   );

   etx_fifo i_fifo (
      .clk(clk), .nreset(nreset),
      .in_access(rm_access), .in_packet(rm_packet), .in_wait(rm_wait),
      .out_access(ff_access), .out_packet(ff_packet), .out_wait(ff_wait),
      .count(ff_count), .full(ff_full)
   );

   etx_serializer i_ser (
      .clk(clk), .nreset(nreset),
      .in_access(ff_access), .in_packet(ff_packet), .in_wait(ff_wait),
      .gpio_enable(gpio_enable), .gpio_data(gpio_data),
      .txo_data(txo_data), .txo_frame(txo_frame),
      .sent(ser_sent), .busy(ser_busy)
   );

endmodule

`default_nettype wire

// ==== bench/etx_checker.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "etx_config.svh"

module etx_checker (
   input  wire                  clk,
   input  wire                  nreset,
   input  wire                  mi_en,
   input  wire                  mi_we,
   input  wire [`ETX_RFAW+1:0]  mi_addr,
   input  wire [31:0]           mi_din,
   input  wire [31:0]           mi_dout,
   input  wire                  pkt_access,
   input  etx_pkg::packet_t     pkt_in,
   input  wire                  pkt_wait,
   input  wire [7:0]            txo_data,
   input  wire                  txo_frame,
   input  wire                  run_done,
   output int                   pin_errs,
   output int                   rb_errs,
   output int                   other_errs
);

   logic [10:0]      cfg_m;          // config as seen on the bus
   logic [2:0]       sticky_m;
   logic [8:0]       gpio_m;         // pins while forced
   logic [15:0]      version_m;
   logic             drop_m;         // drop flop inside remap
   logic [31:0]      exp_dout;       // due on mi_dout next edge
   logic [31:0]      exp_mask;
   etx_pkg::packet_t exp_q[$];       // accepted, first byte not yet out
   etx_pkg::packet_t cur;            // frame on the pins
   int               byte_idx;
   int               stall_cycles;   // pkt_wait high while forced
   logic             done_seen;

   // alias and bypass rules
   function automatic etx_pkg::packet_t expected_packet(input etx_pkg::packet_t p,
                                                        input logic [10:0] c);
      etx_pkg::packet_t q;
      q = p;
      if (c[3:2] == 2'b01 && p.dstaddr[31:20] == 12'h000)
         q.dstaddr[31:20] = p.srcaddr[31:20];
      if (c[8])
         q.ctrlmode = c[7:4];
      return q;
   endfunction

   always @(posedge clk) begin
      logic                 gpio_on;
      logic                 sent_now;
      logic                 idle;
      logic [`ETX_RFAW-1:0] waddr;
      if (!nreset) begin
         cfg_m        = '0;
         sticky_m     = '0;
         version_m    = 16'h0102;
         drop_m       = 1'b0;
         exp_dout     = '0;
         exp_mask     = '1;
         byte_idx     = 0;
         stall_cycles = 0;
         done_seen    = 1'b0;
         pin_errs     = 0;
         rb_errs      = 0;
         other_errs   = 0;
         exp_q.delete();
      end
      else begin
         gpio_on  = (cfg_m[10:9] == 2'b01);
         sent_now = 1'b0;
         waddr    = mi_addr[`ETX_RFAW+1:2];
         idle     = exp_q.size() == 0 && byte_idx == 0 && !(txo_frame && !gpio_on);

         if ((mi_dout & exp_mask) !== (exp_dout & exp_mask)) begin
            $display("ERR mi_dout got %h expected %h", mi_dout & exp_mask, exp_dout & exp_mask);
            rb_errs++;
         end

         // remap register plus a full buffer, fewer held must not stall
         if (pkt_wait && exp_q.size() < `ETX_FIFO_DEPTH + 1) begin
            $display("ERR pkt_wait got %h expected %h", pkt_wait, 1'b0);
            other_errs++;
         end

         // ###################################################################
         // pins
         // ###################################################################
         if (gpio_on) begin
            if ({txo_frame, txo_data} !== gpio_m) begin
               $display("ERR txo_frame/txo_data got %h expected %h", {txo_frame, txo_data}, gpio_m);
               pin_errs++;
            end
            if (pkt_wait)
               stall_cycles++;
         end
         else if (txo_frame) begin
            if (byte_idx == 0) begin
               if (exp_q.size() == 0) begin
                  $display("frame started with no packet outstanding");
                  other_errs++;
                  cur = '0;
               end
               else
                  cur = exp_q.pop_front();
            end
            if (txo_data !== cur[byte_idx*8 +: 8]) begin
               $display("ERR txo_data byte %0d got %h expected %h", byte_idx, txo_data,
                        cur[byte_idx*8 +: 8]);
               pin_errs++;
            end
            sent_now = (byte_idx == 12);   // last of 13
            byte_idx = sent_now ? 0 : byte_idx + 1;
         end
         else if (byte_idx != 0) begin
            $display("frame ended after %0d bytes", byte_idx);
            other_errs++;
            byte_idx = 0;
         end

         // readback due next edge, live bits only known when idle
         exp_dout = '0;
         exp_mask = '1;
         if (mi_en && !mi_we) begin
            case (waddr)
               `ETX_CFG:    exp_dout = {21'b0, cfg_m};
               `ETX_STATUS: begin
                  exp_dout = {29'b0, sticky_m};
                  exp_mask = idle ? 32'hffff_fffd : 32'hffff_ff85;   // full never modelled
               end
               `ETX_GPIO:   exp_dout = {23'b0, gpio_m};
               `E_VERSION:  exp_dout = {16'b0, version_m};
               default:     exp_dout = '0;
            endcase
         end

         if (pkt_access && !pkt_wait && cfg_m[0])
            exp_q.push_back(expected_packet(pkt_in, cfg_m));   // rules at accept time

         if (mi_en && mi_we && waddr == `ETX_STATUS)
            sticky_m = mi_din[2:0];   // write wins over pulses
         else
            sticky_m = sticky_m | {drop_m, 1'b0, sent_now};
         drop_m = pkt_access && !pkt_wait && !cfg_m[0];

         if (mi_en && mi_we) begin
            case (waddr)
               `ETX_CFG:   cfg_m     = mi_din[10:0];
               `ETX_GPIO:  gpio_m    = mi_din[8:0];
               `E_VERSION: version_m = mi_din[15:0];
               default:    ;
            endcase
         end

         if (run_done && !done_seen) begin
            done_seen = 1'b1;
            if (stall_cycles == 0) begin
               $display("pkt_wait never rose while the pins were forced");
               other_errs++;
            end
            if (exp_q.size() != 0 || byte_idx != 0) begin
               $display("%0d packets never left the link", exp_q.size());
               other_errs++;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== bench/etx_tb.sv ====
`timescale 1ns/1ns
`default_nettype none
`include "etx_config.svh"

module etx_tb;

   localparam int n_pkts = 200;                     // packets over all phases
   localparam int limit  = n_pkts * 13 * 4 + 2000;  // watchdog, in cycles

   logic                 clk;
   logic                 nreset;
   logic                 mi_en;
   logic                 mi_we;
   logic [`ETX_RFAW+1:0] mi_addr;
   logic [31:0]          mi_din;
   wire  [31:0]          mi_dout;
   logic                 pkt_access;
   etx_pkg::packet_t     pkt_in;
   wire                  pkt_wait;
   wire  [7:0]           txo_data;
   wire                  txo_frame;
   logic                 run_done;    // tells the checker to close out
   int                   pin_errs;
   int                   rb_errs;
   int                   other_errs;
   logic [31:0]          lfsr;        // stimulus state

   etx_top     i_etx_top (.*);
   etx_checker i_checker (.*);

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;   // 20 ns period
   end

   initial begin
      repeat (limit) @(posedge clk);
      $display("timeout after %0d cycles, traffic never drained", limit);
      $display("Checks failed");
      $finish;
   end

   // ##########################################################################
   // random source, galois form
   // ##########################################################################

   function automatic logic next_bit();
      logic out;
      out  = lfsr[0];
      lfsr = lfsr >> 1;
      if (out)
         lfsr = lfsr ^ 32'h8020_0003;   // x^32 + x^22 + x^2 + x + 1
      return out;
   endfunction

   function automatic logic [31:0] take_bits(input int n);
      logic [31:0] v;
      v = '0;
      for (int i = 0; i < n; i++)
         v[i] = next_bit();   // one step per bit
      return v;
   endfunction

   function automatic etx_pkg::packet_t random_packet(input logic short_dst);
      etx_pkg::packet_t p;
      p.write    = 1'(take_bits(1));
      p.datamode = 2'(take_bits(2));
      p.reserved = 1'(take_bits(1));
      p.ctrlmode = 4'(take_bits(4));
      p.dstaddr  = take_bits(32);
      p.data     = take_bits(32);
      p.srcaddr  = take_bits(32);
      if (short_dst)
         p.dstaddr[31:20] = 12'h000;   // candidate for aliasing
      return p;
   endfunction

   // ##########################################################################
   // bus and packet drivers, all on falling edges
   // ##########################################################################

   task automatic bus_cycle(input logic we, input logic [`ETX_RFAW-1:0] word,
                            input logic [31:0] data);
      @(negedge clk);
      mi_en   = 1'b1;
      mi_we   = we;
      mi_addr = {word, 2'b00};
      mi_din  = data;
      @(negedge clk);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   task automatic send_burst(input int n, input logic mix_short);
      for (int i = 0; i < n; i++) begin
         @(negedge clk);
         pkt_access = 1'b1;
         pkt_in     = random_packet(mix_short & next_bit());
         while (pkt_wait)
            @(negedge clk);   // hold until the edge can take it
      end
      @(negedge clk);
      pkt_access = 1'b0;
   endtask

   // frame and wait both quiet for a while
   task automatic wait_idle();
      int quiet;
      quiet = 0;
      while (quiet < 20) begin
         @(negedge clk);
         if (txo_frame || pkt_wait)
            quiet = 0;
         else
            quiet++;
      end
   endtask

   initial begin
      logic [31:0] cfg_val;
      nreset     = 1'b0;
      mi_en      = 1'b0;
      mi_we      = 1'b0;
      mi_addr    = '0;
      mi_din     = '0;
      pkt_access = 1'b0;
      pkt_in     = '0;
      run_done   = 1'b0;
      lfsr       = 32'hd787;
      repeat (3) @(posedge clk);
      @(negedge clk);
      nreset = 1'b1;

      // registers, version first for its reset value
      bus_cycle(1'b0, `E_VERSION, '0);
      for (int r = 0; r < 8; r++) begin
         bus_cycle(1'b1, `ETX_GPIO, take_bits(32));
         bus_cycle(1'b1, `E_VERSION, take_bits(32));
         bus_cycle(1'b1, `ETX_STATUS, take_bits(32));
         bus_cycle(1'b1, `ETX_CFG, take_bits(32));
         bus_cycle(1'b1, 6'(4 + take_bits(5)), take_bits(32));   // hole, ignored
         for (int a = 0; a < 4; a++)
            bus_cycle(1'b0, 6'(a), '0);
         bus_cycle(1'b0, 6'(4 + take_bits(5)), '0);
      end

      // plain transfer
      bus_cycle(1'b1, `ETX_CFG, 32'h1);
      send_burst(60, 1'b0);
      wait_idle();

      // alias plus bypass, then mode 11 which must not alias
      cfg_val = 32'h105 | (take_bits(4) << 4);
      bus_cycle(1'b1, `ETX_CFG, cfg_val);
      send_burst(30, 1'b1);
      bus_cycle(1'b1, `ETX_CFG, 32'h00d);
      send_burst(30, 1'b1);
      wait_idle();

      // transmit off so everything is swallowed
      bus_cycle(1'b1, `ETX_CFG, 32'h0);
      send_burst(20, 1'b0);
      bus_cycle(1'b0, `ETX_STATUS, '0);
      bus_cycle(1'b1, `ETX_STATUS, 32'h0);
      bus_cycle(1'b0, `ETX_STATUS, '0);

      // pins forced, buffer backs up into pkt_wait
      bus_cycle(1'b1, `ETX_CFG, 32'h1);
      bus_cycle(1'b1, `ETX_GPIO, take_bits(9));
      bus_cycle(1'b1, `ETX_CFG, 32'h201);
      fork
         send_burst(8, 1'b0);
         begin
            while (!pkt_wait)
               @(negedge clk);
            repeat (10) @(negedge clk);
            bus_cycle(1'b1, `ETX_GPIO, take_bits(9));
            bus_cycle(1'b0, `ETX_STATUS, '0);
            bus_cycle(1'b1, `ETX_CFG, 32'h1);   // release the pins
         end
      join
      wait_idle();

      // mixed traffic with a forcing window in the middle of frames
      cfg_val = 32'h105 | (take_bits(4) << 4);
      bus_cycle(1'b1, `ETX_CFG, cfg_val);
      fork
         send_burst(52, 1'b1);
         begin
            repeat (150) @(negedge clk);
            bus_cycle(1'b1, `ETX_CFG, cfg_val | 32'h200);
            repeat (20) @(negedge clk);
            bus_cycle(1'b1, `ETX_CFG, cfg_val);
         end
      join
      wait_idle();
      bus_cycle(1'b0, `ETX_STATUS, '0);   // sticky sent, count back to zero
      bus_cycle(1'b0, `ETX_CFG, '0);

      run_done = 1'b1;
      repeat (2) @(negedge clk);
      $display("errors: pins %0d, readback %0d, other %0d", pin_errs, rb_errs, other_errs);
      if (pin_errs + rb_errs + other_errs == 0)
         $display("All checks passed");
      else
         $display("Checks failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+source
source/etx_pkg.sv
source/etx_cfg.sv
source/etx_remap.sv
source/etx_fifo.sv
source/etx_serializer.sv
source/etx_top.sv
bench/etx_checker.sv
bench/etx_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the link transmit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module etx_tb -f list.f -o etx_sim

# exit status of the pipe is the one from tee, so the log decides
./obj_dir/etx_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
   echo "PASS"
else
   echo "FAIL"
   exit 1
fi
